// File: rtl/jts16_char_pkg.sv
// Character layer package: raster constants, width types, bus structs and fetch states
package jts16_char_pkg;

    // Raster size, reduced for short simulations
    localparam int H_VISIBLE = 64;
    localparam int H_TOTAL   = 96;
    localparam int V_VISIBLE = 32;
    localparam int V_TOTAL   = 40;

    // Sync windows, both inside blanking
    localparam int HS_START  = 72;
    localparam int HS_END    = 80;
    localparam int VS_START  = 34;
    localparam int VS_END    = 36;

    localparam int TILES_PER_LINE = H_VISIBLE / 8;
    localparam int H_VIS_W        = $clog2(H_VISIBLE);

    typedef logic [6:0]  hpos_t;
    typedef logic [5:0]  vpos_t;
    typedef logic [9:0]  tile_code_t;
    typedef logic [2:0]  pal_sel_t;
    typedef logic [3:0]  pix_t;
    typedef logic [12:0] char_addr_t;

    // Tile map word as written by the CPU
    typedef struct packed {
        logic [2:0] rsvd;
        pal_sel_t   pal;
        tile_code_t code;
    } map_entry_t;

    // Line buffer word, also the palette index
    typedef struct packed {
        pal_sel_t pal;
        pix_t     pix;
    } lb_pix_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    // CPU write bus, addr is the word address
    typedef struct packed {
        logic [11:0] addr;
        logic [15:0] dout;
        logic        we;
    } cpu_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        MAP_RD,
        ROM_WAIT,
        WRITE
    } fetch_state_t;

endpackage

// File: rtl/jts16_char_vtimer.sv
// Pixel clock enable, raster counters, blanking and sync generation
module jts16_char_vtimer import jts16_char_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output logic  pxl_cen,
    output hpos_t hdump,
    output vpos_t vdump,
    output logic  line_start,
    output logic  LHBL,
    output logic  LVBL,
    output logic  HS,
    output logic  VS
);

    logic h_last;
    logic v_last;

    assign h_last = hdump == hpos_t'(H_TOTAL - 1);
    assign v_last = vdump == vpos_t'(V_TOTAL - 1);

    // Starts on the last line of the frame so the outputs begin in blanking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl_cen    <= 1'b0;
            hdump      <= '0;
            vdump      <= vpos_t'(V_TOTAL - 1);
            line_start <= 1'b0;
        end else begin
            pxl_cen    <= ~pxl_cen;
            // High in the same clk as hdump returns to zero
            line_start <= pxl_cen && h_last;
            if (pxl_cen) begin
                if (h_last) begin
                    hdump <= '0;
                    vdump <= v_last ? '0 : vdump + 1'b1;
                end else begin
                    hdump <= hdump + 1'b1;
                end
            end
        end
    end

    assign LHBL = hdump < hpos_t'(H_VISIBLE);
    assign LVBL = vdump < vpos_t'(V_VISIBLE);

    // Active high syncs
    assign HS = (hdump >= hpos_t'(HS_START)) && (hdump < hpos_t'(HS_END));
    assign VS = (vdump >= vpos_t'(VS_START)) && (vdump < vpos_t'(VS_END));

endmodule

// File: rtl/jts16_char_fetch.sv
// Tile map RAM with CPU writes and per-line tile row fetch into the line buffer
module jts16_char_fetch import jts16_char_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        line_start,
    input  vpos_t       vdump,
    input  cpu_wr_t     cpu,
    input  logic        char_cs,
    output char_addr_t  char_addr,
    input  logic [31:0] char_data,
    input  logic        char_ok,
    output logic        lb_we,
    output hpos_t       lb_waddr,
    output lb_pix_t     lb_wdata,
    output logic        lb_wsel
);

    fetch_state_t state;

    map_entry_t   map_ram [256];
    map_entry_t   map_q;
    logic [7:0]   map_raddr;

    vpos_t        rline;
    vpos_t        next_line;
    logic [2:0]   col;
    logic         last_tile;
    logic [31:0]  rom_word;

    // Pixel writer, drains one tile row while the next one is fetched
    logic         wr_busy;
    logic [2:0]   wr_pix;
    logic [2:0]   wr_col;
    pal_sel_t     wr_pal;
    logic [31:0]  wr_word;

    // The line after the one on screen, wrapping at the frame end
    assign next_line = (vdump == vpos_t'(V_TOTAL - 1)) ? '0 : vdump + 1'b1;
    assign map_raddr = {2'b00, rline[5:3], col};
    assign last_tile = col == 3'(TILES_PER_LINE - 1);

    always_ff @(posedge clk) begin
        if (char_cs && cpu.we) begin
            map_ram[cpu.addr[7:0]] <= map_entry_t'(cpu.dout);
        end
    end

    // Map word stays put until the next tile, so the ROM address is stable
    always_ff @(posedge clk) begin
        if (state == MAP_RD) begin
            map_q <= map_ram[map_raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (state == ROM_WAIT && char_ok) begin
            rom_word <= char_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            rline <= '0;
            col   <= '0;
        end else if (line_start) begin
            // A new line always restarts the fetch
            state <= MAP_RD;
            rline <= next_line;
            col   <= '0;
        end else begin
            case (state)
                MAP_RD: begin
                    state <= ROM_WAIT;
                end
                ROM_WAIT: begin
                    if (char_ok) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    // Hand over to the writer once it is free
                    if (!wr_busy) begin
                        col   <= col + 1'b1;
                        state <= last_tile ? IDLE : MAP_RD;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
            wr_pix  <= '0;
        end else if (line_start) begin
            wr_busy <= 1'b0;
            wr_pix  <= '0;
        end else if (state == WRITE && !wr_busy) begin
            wr_busy <= 1'b1;
            wr_pix  <= '0;
        end else if (wr_busy) begin
            wr_pix <= wr_pix + 1'b1;
            if (wr_pix == 3'd7) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // Pixel 0 sits in the low nibble
    always_ff @(posedge clk) begin
        if (state == WRITE && !wr_busy) begin
            wr_word <= rom_word;
            wr_pal  <= map_q.pal;
            wr_col  <= col;
        end else if (wr_busy) begin
            wr_word <= wr_word >> 4;
        end
    end

    assign char_addr = {map_q.code, rline[2:0]};

    assign lb_we         = wr_busy;
    assign lb_waddr      = hpos_t'({wr_col, wr_pix});
    assign lb_wdata.pal  = wr_pal;
    assign lb_wdata.pix  = wr_word[3:0];
    assign lb_wsel       = rline[0];

endmodule

// File: rtl/jts16_char_linebuf.sv
// Double line buffer, one half filled while the other is scanned out
module jts16_char_linebuf import jts16_char_pkg::*; (
    input  logic    clk,
    input  logic    lb_we,
    input  logic    lb_wsel,
    input  hpos_t   lb_waddr,
    input  lb_pix_t lb_wdata,
    input  logic    lb_rsel,
    input  hpos_t   lb_raddr,
    output lb_pix_t lb_rdata
);

    lb_pix_t mem [2 * H_VISIBLE];

    logic [H_VIS_W:0] waddr;
    logic [H_VIS_W:0] raddr;

    // Half select is the top address bit
    assign waddr = {lb_wsel, lb_waddr[H_VIS_W-1:0]};
    assign raddr = {lb_rsel, lb_raddr[H_VIS_W-1:0]};

    always_ff @(posedge clk) begin
        if (lb_we && lb_waddr < hpos_t'(H_VISIBLE)) begin
            mem[waddr] <= lb_wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        lb_rdata <= mem[raddr];
    end

endmodule

// File: rtl/jts16_char_scan.sv
// Palette RAM with CPU writes, line buffer read-out, colour lookup and delayed blank/sync
module jts16_char_scan import jts16_char_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  hpos_t      hdump,
    input  vpos_t      vdump,
    input  logic       LHBL,
    input  logic       LVBL,
    input  logic       HS,
    input  logic       VS,
    input  cpu_wr_t    cpu,
    input  logic       pal_cs,
    output logic       lb_rsel,
    output hpos_t      lb_raddr,
    input  lb_pix_t    lb_rdata,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output logic       HS_dly,
    output logic       VS_dly
);

    rgb_t    pal_ram [128];
    rgb_t    pal_q;
    rgb_t    rgb;
    lb_pix_t pix_r;

    logic    lhbl_d1;
    logic    lvbl_d1;
    logic    hs_d1;
    logic    vs_d1;

    // Read the half that was filled during the previous line
    assign lb_rsel  = vdump[0];
    assign lb_raddr = hdump;

    always_ff @(posedge clk) begin
        if (pal_cs && cpu.we) begin
            pal_ram[cpu.addr[6:0]] <= rgb_t'(cpu.dout[14:0]);
        end
    end

    // First pixel stage
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pix_r <= lb_rdata;
        end
    end

    // Palette read every clk, settles before the next pixel enable
    always_ff @(posedge clk) begin
        pal_q <= pal_ram[{pix_r.pal, pix_r.pix}];
    end

    // Second stage, blanks and syncs follow the pixel by two periods
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            hs_d1    <= 1'b0;
            vs_d1    <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            HS_dly   <= 1'b0;
            VS_dly   <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= LHBL;
            lvbl_d1  <= LVBL;
            hs_d1    <= HS;
            vs_d1    <= VS;
            LHBL_dly <= lhbl_d1;
            LVBL_dly <= lvbl_d1;
            HS_dly   <= hs_d1;
            VS_dly   <= vs_d1;
            // Black during blanking
            rgb      <= (lhbl_d1 && lvbl_d1) ? pal_q : '0;
        end
    end

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

endmodule

// File: rtl/jts16_char_game.sv
// Character layer top level: timer, tile fetcher, line buffer and scan-out
module jts16_char_game import jts16_char_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // CPU writes
    input  cpu_wr_t     cpu,
    input  logic        char_cs,
    input  logic        pal_cs,
    // Graphics ROM
    output char_addr_t  char_addr,
    input  logic [31:0] char_data,
    input  logic        char_ok,
    // Video
    output logic        pxl_cen,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output logic        HS,
    output logic        VS
);

    hpos_t   hdump;
    vpos_t   vdump;
    logic    line_start;
    logic    LHBL;
    logic    LVBL;
    logic    hs_raw;
    logic    vs_raw;

    logic    lb_we;
    logic    lb_wsel;
    hpos_t   lb_waddr;
    lb_pix_t lb_wdata;
    logic    lb_rsel;
    hpos_t   lb_raddr;
    lb_pix_t lb_rdata;

    jts16_char_vtimer u_vtimer (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .line_start ( line_start ),
        .LHBL       ( LHBL       ),
        .LVBL       ( LVBL       ),
        .HS         ( hs_raw     ),
        .VS         ( vs_raw     )
    );

    jts16_char_fetch u_fetch (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .line_start ( line_start ),
        .vdump      ( vdump      ),
        .cpu        ( cpu        ),
        .char_cs    ( char_cs    ),
        .char_addr  ( char_addr  ),
        .char_data  ( char_data  ),
        .char_ok    ( char_ok    ),
        .lb_we      ( lb_we      ),
        .lb_waddr   ( lb_waddr   ),
        .lb_wdata   ( lb_wdata   ),
        .lb_wsel    ( lb_wsel    )
    );

    jts16_char_linebuf u_linebuf (
        .clk        ( clk        ),
        .lb_we      ( lb_we      ),
        .lb_wsel    ( lb_wsel    ),
        .lb_waddr   ( lb_waddr   ),
        .lb_wdata   ( lb_wdata   ),
        .lb_rsel    ( lb_rsel    ),
        .lb_raddr   ( lb_raddr   ),
        .lb_rdata   ( lb_rdata   )
    );

    jts16_char_scan u_scan (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .LHBL       ( LHBL       ),
        .LVBL       ( LVBL       ),
        .HS         ( hs_raw     ),
        .VS         ( vs_raw     ),
        .cpu        ( cpu        ),
        .pal_cs     ( pal_cs     ),
        .lb_rsel    ( lb_rsel    ),
        .lb_raddr   ( lb_raddr   ),
        .lb_rdata   ( lb_rdata   ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .LHBL_dly   ( LHBL_dly   ),
        .LVBL_dly   ( LVBL_dly   ),
        .HS_dly     ( HS         ),
        .VS_dly     ( VS         )
    );

endmodule

// File: sim/char_rom_model.sv
// Graphics ROM model with address-derived data and per-request latency
module char_rom_model import jts16_char_pkg::*; (
    input  logic        clk,
    input  char_addr_t  char_addr,
    input  logic [4:0]  latency,
    output logic [31:0] char_data,
    output logic        char_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    char_addr_t addr_q;
    logic [4:0] lat_q;
    int         remain;

    // Fixed hash, every nibble depends on the whole address
    function automatic logic [31:0] word_at(input char_addr_t a);
        logic [31:0] w;
        w = {19'd0, a} * 32'h9E37_79B1;
        return w ^ (w >> 15);
    endfunction

    initial begin
        addr_q    = '1;
        remain    = 0;
        char_ok   = 1'b0;
        char_data = '0;
    end

    // A new address starts a request; ok stays high while the address holds
    always @(posedge clk) begin
        lat_q = latency;
        #1;
        if (char_addr !== addr_q) begin
            addr_q = char_addr;
            remain = (lat_q == 0) ? 1 : lat_q;
        end
        if (remain > 0) begin
            remain--;
        end
        char_ok   = remain == 0;
        // Garbage on the bus until the data is ready
        char_data = char_ok ? word_at(addr_q) : ~word_at(addr_q);
    end

endmodule

// File: sim/tb_char_game.sv
// Testbench for the character layer with CPU writes, frame capture and directed checks
module tb_char_game import jts16_char_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS    = 100;
    localparam int NPIX      = H_VISIBLE * V_VISIBLE;
    localparam int FRAME_PIX = H_TOTAL * V_TOTAL;
    localparam int MAP_WORDS = TILES_PER_LINE * (V_TOTAL / 8);
    localparam int SEED      = 14;

    logic        clk = 1'b0;
    logic        rst_n;
    cpu_wr_t     cpu;
    logic        char_cs;
    logic        pal_cs;
    char_addr_t  char_addr;
    logic [31:0] char_data;
    logic        char_ok;
    logic        pxl_cen;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic        HS;
    logic        VS;
    logic [4:0]  rom_latency;
    logic        lat_random;

    logic [15:0] map_mem [MAP_WORDS];
    logic [14:0] pal_mem [128];
    logic [14:0] frame [NPIX];
    logic [14:0] prev_frame [NPIX];
    bit          touched [128];
    int          errors;
    int          checks;
    logic [31:0] rnd_state;
    logic [31:0] lat_state;

    always #(CLK_NS / 2) clk = ~clk;

    jts16_char_game u_dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cpu       ( cpu       ),
        .char_cs   ( char_cs   ),
        .pal_cs    ( pal_cs    ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .pxl_cen   ( pxl_cen   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .HS        ( HS        ),
        .VS        ( VS        )
    );

    char_rom_model u_rom (
        .clk       ( clk         ),
        .char_addr ( char_addr   ),
        .latency   ( rom_latency ),
        .char_data ( char_data   ),
        .char_ok   ( char_ok     )
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = lcg_step(rnd_state);
        return rnd_state;
    endfunction

    // Draws a latency of 1 to 16 every clk for the next ROM request
    always @(posedge clk) begin
        #1;
        if (lat_random) begin
            lat_state   = lcg_step(lat_state);
            rom_latency = {1'b0, lat_state[19:16]} + 5'd1;
        end
    end

    // Same hash as the ROM contents
    function automatic logic [31:0] rom_word(input logic [12:0] a);
        logic [31:0] w;
        w = {19'd0, a} * 32'h9E37_79B1;
        return w ^ (w >> 15);
    endfunction

    // Palette index {pal, nibble} shown at pixel x, y
    function automatic logic [6:0] pixel_index(input int x, input int y);
        logic [15:0] entry;
        logic [2:0]  row;
        logic [31:0] word;
        entry = map_mem[(y / 8) * TILES_PER_LINE + x / 8];
        row   = 3'(y % 8);
        word  = rom_word({entry[9:0], row});
        return {entry[12:10], word[4 * (x % 8) +: 4]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0d ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0d ns: %s", $time, why);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic cpu_write(input logic [11:0] addr, input logic [15:0] data,
                             input logic to_pal);
        @(posedge clk);
        #1;
        cpu     = {addr, data, 1'b1};
        char_cs = !to_pal;
        pal_cs  = to_pal;
        @(posedge clk);
        #1;
        cpu.we  = 1'b0;
        char_cs = 1'b0;
        pal_cs  = 1'b0;
    endtask

    task automatic write_map(input logic [11:0] addr, input logic [15:0] data);
        cpu_write(addr, data, 1'b0);
    endtask

    task automatic write_pal(input logic [11:0] addr, input logic [15:0] data);
        cpu_write(addr, data, 1'b1);
    endtask

    // Moves to the next falling edge at which pxl_cen is high
    task automatic step_pixel();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pxl_cen && n < 4);
        if (!pxl_cen) begin
            abort_run("pxl_cen stopped toggling");
        end
    endtask

    task automatic wait_frame_start();
        logic prev_v;
        bit   found;
        int   n;
        prev_v = 1'b1;
        found  = 1'b0;
        for (n = 0; n < FRAME_PIX + 8 && !found; n++) begin
            step_pixel();
            found  = LVBL_dly && !prev_v;
            prev_v = LVBL_dly;
        end
        if (!found) begin
            abort_run("timed out waiting for LVBL_dly to rise");
        end
    endtask

    task automatic capture_frame();
        int idx;
        int n;
        idx = 0;
        wait_frame_start();
        for (n = 0; n < FRAME_PIX && idx < NPIX; n++) begin
            if (n > 0) begin
                step_pixel();
            end
            if (LHBL_dly && LVBL_dly) begin
                frame[idx] = {red, green, blue};
                idx++;
            end
        end
        if (idx != NPIX) begin
            abort_run("visible area ended before a full frame was captured");
        end
    endtask

    task automatic check_image();
        int x;
        int y;
        for (y = 0; y < V_VISIBLE; y++) begin
            for (x = 0; x < H_VISIBLE; x++) begin
                check_val($sformatf("rgb[%0d,%0d]", x, y), pal_mem[pixel_index(x, y)],
                          frame[y * H_VISIBLE + x]);
            end
        end
    endtask

    task automatic load_random_map();
        logic [31:0] r;
        int          i;
        for (i = 0; i < MAP_WORDS; i++) begin
            r          = next_rand();
            map_mem[i] = r[31:16];
            write_map(12'(i), r[31:16]);
        end
    endtask

    task automatic load_random_pal();
        logic [31:0] r;
        int          i;
        for (i = 0; i < 128; i++) begin
            r          = next_rand();
            pal_mem[i] = r[30:16];
            write_pal(12'(i), {1'b0, r[30:16]});
        end
    endtask

    task automatic check_idle(input string when);
        check_val({"red ", when}, 0, red);
        check_val({"green ", when}, 0, green);
        check_val({"blue ", when}, 0, blue);
        check_val({"HS ", when}, 0, HS);
        check_val({"VS ", when}, 0, VS);
        check_val({"LHBL_dly ", when}, 0, LHBL_dly);
        check_val({"LVBL_dly ", when}, 0, LVBL_dly);
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        check_idle("in reset");
        rst_n = 1'b1;
        step_pixel();
        check_idle("after reset");
    endtask

    // Counts lines and pixels between HS rises over one VS period
    task automatic test_raster();
        logic prev_hs;
        logic prev_vs;
        bit   started;
        bit   done;
        int   lines;
        int   vis_lines;
        int   pix;
        int   hvis;
        int   n;
        time  t_hs;
        prev_vs = 1'b1;
        done    = 1'b0;
        for (n = 0; n < FRAME_PIX + 8 && !done; n++) begin
            step_pixel();
            done    = VS && !prev_vs;
            prev_vs = VS;
        end
        if (!done) begin
            abort_run("timed out waiting for VS to rise");
        end
        prev_hs   = HS;
        started   = 1'b0;
        done      = 1'b0;
        lines     = 0;
        vis_lines = 0;
        pix       = 0;
        hvis      = 0;
        t_hs      = 0;
        for (n = 0; n < FRAME_PIX + H_TOTAL && !done; n++) begin
            step_pixel();
            if (HS && !prev_hs) begin
                if (started) begin
                    check_val("pixels per HS period", H_TOTAL, pix);
                    check_val("visible pixels per line", H_VISIBLE, hvis);
                    // One pixel every second clk
                    check_val("clks per HS period", 2 * H_TOTAL,
                              32'(($time - t_hs) / CLK_NS));
                end
                started = 1'b1;
                t_hs    = $time;
                lines++;
                vis_lines += LVBL_dly;
                pix  = 0;
                hvis = 0;
            end
            pix++;
            hvis += LHBL_dly;
            done    = VS && !prev_vs;
            prev_hs = HS;
            prev_vs = VS;
        end
        if (!done) begin
            abort_run("VS did not come back within one frame");
        end
        check_val("lines per VS period", V_TOTAL, lines);
        check_val("visible lines per frame", V_VISIBLE, vis_lines);
    endtask

    task automatic test_image_fixed_latency();
        load_random_pal();
        load_random_map();
        wait_frame_start();
        capture_frame();
        check_image();
    endtask

    task automatic test_image_random_latency();
        lat_random = 1'b1;
        load_random_map();
        wait_frame_start();
        capture_frame();
        lat_random = 1'b0;
        check_image();
    endtask

    // Rewrites four palette words that are visible on screen
    task automatic test_palette_rewrite();
        logic [31:0] r;
        logic [6:0]  idx;
        int          changed;
        int          i;
        changed = 0;
        for (i = 0; i < NPIX; i++) begin
            prev_frame[i] = frame[i];
        end
        for (i = 0; i < 128; i++) begin
            touched[i] = 1'b0;
        end
        for (i = 0; i < 4; i++) begin
            r   = next_rand();
            idx = pixel_index(r[21:16], r[28:24]);
            if (!touched[idx]) begin
                touched[idx] = 1'b1;
                pal_mem[idx] = pal_mem[idx] ^ 15'h7FFF;
                write_pal({5'd0, idx}, {1'b0, pal_mem[idx]});
            end
        end
        wait_frame_start();
        capture_frame();
        check_image();
        for (i = 0; i < NPIX; i++) begin
            idx = pixel_index(i % H_VISIBLE, i / H_VISIBLE);
            if (!touched[idx]) begin
                check_val($sformatf("unchanged pixel %0d", i), prev_frame[i], frame[i]);
            end else if (frame[i] !== prev_frame[i]) begin
                changed++;
            end
        end
        check_val("some pixels changed", 1, changed != 0);
    endtask

    task automatic test_blank_black();
        int blanks;
        int n;
        blanks = 0;
        wait_frame_start();
        for (n = 0; n < FRAME_PIX; n++) begin
            if (n > 0) begin
                step_pixel();
            end
            if (!(LHBL_dly && LVBL_dly)) begin
                blanks++;
                check_val("rgb in blanking", 0, {red, green, blue});
            end
        end
        check_val("blanking samples per frame", FRAME_PIX - NPIX, blanks);
    endtask

    initial begin
        rst_n       = 1'b0;
        cpu         = '0;
        char_cs     = 1'b0;
        pal_cs      = 1'b0;
        rom_latency = 5'd1;
        lat_random  = 1'b0;
        errors      = 0;
        checks      = 0;
        rnd_state   = SEED;
        lat_state   = SEED;

        test_reset();
        test_raster();
        test_image_fixed_latency();
        test_image_random_latency();
        test_palette_rewrite();
        test_blank_black();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/jts16_char_pkg.sv
rtl/jts16_char_vtimer.sv
rtl/jts16_char_fetch.sv
rtl/jts16_char_linebuf.sv
rtl/jts16_char_scan.sv
rtl/jts16_char_game.sv
sim/char_rom_model.sv
sim/tb_char_game.sv

// File: Bender.yml
package:
  name: jts16_char

sources:
  - files:
      - rtl/jts16_char_pkg.sv
      - rtl/jts16_char_vtimer.sv
      - rtl/jts16_char_fetch.sv
      - rtl/jts16_char_linebuf.sv
      - rtl/jts16_char_scan.sv
      - rtl/jts16_char_game.sv
  - target: simulation
    files:
      - sim/char_rom_model.sv
      - sim/tb_char_game.sv
